// ==== src/memConfigPkg.sv ====
package memConfigPkg;

    // Data memory geometry
    localparam int MEM_WORDS      = 256;  // 32-bit words
    localparam int WORD_ADDR_BITS = 8;    // Word index width

    // Slow memory model
    localparam int WAIT_CYCLES = 2;  // Wait states per access
    localparam int TIMER_BITS  = 2;  // Must hold WAIT_CYCLES

    // Byte address bits below the word index
    localparam int BYTE_OFFSET_BITS = 2;

    // Highest byte address still inside the memory
    localparam int LAST_BYTE_ADDR = (MEM_WORDS << BYTE_OFFSET_BITS) - 1;

endpackage

// ==== src/lsuTypesPkg.sv ====
package lsuTypesPkg;

    // funct3 codes of the load and store instructions
    typedef enum logic [2:0] {
        sizeByte  = 3'b000,  // LB / SB
        sizeHalf  = 3'b001,  // LH / SH
        sizeWord  = 3'b010,  // LW / SW
        sizeByteU = 3'b100,  // LBU
        sizeHalfU = 3'b101   // LHU
    } accessSize_t;

    // One memory operation as issued by the core
    typedef struct packed {
        logic        isStore;
        accessSize_t size;
        logic [31:0] addr;       // Byte address
        logic [31:0] storeData;
        logic [31:0] instNum;    // Tag returned with the load
    } lsReq_t;

    // Load value handed back to the core
    typedef struct packed {
        logic [31:0] data;
        logic [31:0] instNum;
    } loadResult_t;

    // Word write command after lane alignment
    typedef struct packed {
        logic [3:0]                               byteEn;
        logic [memConfigPkg::WORD_ADDR_BITS-1:0] wordIndex;
        logic [31:0]                              laneData;
    } storeLanes_t;

    // Sequencer states of the load/store stage
    typedef enum logic [1:0] {
        stIdle,
        stWait,    // Memory wait states
        stAccess,  // Read data returning
        stReport
    } lsuState_t;

endpackage

// ==== src/latencyTimer.sv ====
`timescale 1ns/1ns

module latencyTimer
    import memConfigPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic done
);

    logic [TIMER_BITS-1:0] count;  // Remaining wait states

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= (count == TIMER_BITS'(1));  // Count hits zero on this edge
            if (start) begin
                count <= TIMER_BITS'(WAIT_CYCLES);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        start |-> (count == '0))
        else $error("latencyTimer: start while still counting");

endmodule

// ==== src/storeAlign.sv ====
`timescale 1ns/1ns

module storeAlign
    import lsuTypesPkg::*;
(
    input  lsReq_t      req,
    output storeLanes_t lanes,
    output logic        misaligned
);

    logic [1:0]  offset;
    logic [3:0]  byteEn;
    logic [31:0] laneData;

    assign offset = req.addr[1:0];  // Byte lane within the word

    always_comb begin
        byteEn     = 4'b0000;
        laneData   = req.storeData;
        misaligned = 1'b0;
        case (req.size)
            sizeByte, sizeByteU: begin
                byteEn   = 4'b0001 << offset;
                laneData = {4{req.storeData[7:0]}};  // Same byte on every lane
            end
            sizeHalf, sizeHalfU: begin
                misaligned = offset[0];
                if (!offset[0]) begin
                    byteEn = 4'b0011 << offset;
                end
                laneData = {2{req.storeData[15:0]}};
            end
            sizeWord: begin
                misaligned = (offset != 2'b00);
                if (offset == 2'b00) begin
                    byteEn = 4'b1111;
                end
            end
            default: begin
                misaligned = 1'b1;  // Unknown funct3
            end
        endcase
    end

    assign lanes = '{
        byteEn:    byteEn,
        wordIndex: req.addr[2 +: $bits(lanes.wordIndex)],
        laneData:  laneData
    };

endmodule

// ==== src/dataMemory.sv ====
`timescale 1ns/1ns

module dataMemory
    import memConfigPkg::*, lsuTypesPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        write,
    input  logic        read,
    input  storeLanes_t lanes,
    output logic [31:0] readWord
);

    logic [31:0] mem [MEM_WORDS];

    // Fill pattern and byte-enable writes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= 32'(i + 3);  // Word k holds k + 3
            end
        end else if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (lanes.byteEn[b]) begin
                    mem[lanes.wordIndex][8*b +: 8] <= lanes.laneData[8*b +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (read) begin
            readWord <= mem[lanes.wordIndex];
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !(write && read))
        else $error("dataMemory: read and write in the same cycle");

endmodule

// ==== src/loadAlign.sv ====
`timescale 1ns/1ns

module loadAlign
    import lsuTypesPkg::*;
(
    input  logic [31:0] word,
    input  accessSize_t size,
    input  logic [1:0]  offset,
    output logic [31:0] data
);

    logic [31:0] shifted;
    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // Addressed lane moved down to bit 0
    assign shifted = word >> {offset, 3'b000};
    assign byteSel = shifted[7:0];
    assign halfSel = shifted[15:0];

    always_comb begin
        case (size)
            sizeByte: begin
                data = {{24{byteSel[7]}}, byteSel};  // Sign from the byte itself
            end
            sizeHalf: begin
                data = {{16{halfSel[15]}}, halfSel};
            end
            sizeWord: begin
                data = word;
            end
            sizeByteU: begin
                data = {24'd0, byteSel};
            end
            sizeHalfU: begin
                data = {16'd0, halfSel};
            end
            default: begin
                data = '0;  // Faulted, never reported
            end
        endcase
    end

endmodule

// ==== src/lsuControl.sv ====
`timescale 1ns/1ns

module lsuControl
    import memConfigPkg::*, lsuTypesPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic accept,
    input  logic misaligned,
    input  logic isStore,
    input  logic timerDone,
    output logic timerStart,
    output logic memRead,
    output logic memWrite,
    output logic loadDone,
    output logic storeDone,
    output logic fault,
    output logic busy
);

    lsuState_t state;
    lsuState_t nextState;
    logic      faultSeen;  // Operation ends in a fault report

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (accept) begin
                    nextState = stWait;
                end
            end
            stWait: begin
                if (misaligned) begin
                    nextState = stReport;  // Skip the memory entirely
                end else if (timerDone) begin
                    nextState = stAccess;
                end
            end
            stAccess: nextState = stReport;
            stReport: nextState = stIdle;
            default:  nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= stIdle;
            faultSeen <= 1'b0;
        end else begin
            state <= nextState;
            if (state == stWait) begin
                faultSeen <= misaligned;
            end
        end
    end

    // Timer runs from the accept edge
    assign timerStart = (state == stIdle) && accept;

    // Memory strobes fire on the edge that enters access
    assign memRead  = (state == stWait) && timerDone && !isStore;
    assign memWrite = (state == stWait) && timerDone && isStore;

    assign loadDone  = (state == stReport) && !faultSeen && !isStore;
    assign storeDone = (state == stReport) && !faultSeen && isStore;
    assign fault     = (state == stReport) && faultSeen;
    assign busy      = (state != stIdle);

    assert property (@(posedge clk) disable iff (reset)
        memWrite |-> !misaligned)
        else $error("lsuControl: write issued for a misaligned store");

    // Wait states line up with the timer model
    assert property (@(posedge clk) disable iff (reset)
        timerStart |-> ##(WAIT_CYCLES + 1) timerDone)
        else $error("lsuControl: timer end out of step with WAIT_CYCLES");

endmodule

// ==== src/loadStoreUnit.sv ====
`timescale 1ns/1ns

module loadStoreUnit
    import memConfigPkg::*, lsuTypesPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        reqStrobe,
    input  lsReq_t      req,
    output loadResult_t result,
    output logic        loadDone,
    output logic        storeDone,
    output logic        fault,
    output logic        busy
);

    logic        accept;
    lsReq_t      heldReq;
    storeLanes_t lanes;
    logic        misaligned;
    logic        timerStart;
    logic        timerDone;
    logic        memRead;
    logic        memWrite;
    logic [31:0] readWord;
    logic [31:0] loadData;
    logic        loadCapture;  // readWord valid this cycle

    assign accept = reqStrobe && !busy;  // Strobes while busy are dropped

    always_ff @(posedge clk) begin
        if (accept) begin
            heldReq <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loadCapture <= 1'b0;
            result      <= '0;
        end else begin
            loadCapture <= memRead;
            if (loadCapture) begin
                result <= '{data: loadData, instNum: heldReq.instNum};
            end
        end
    end

    lsuControl i_lsuControl (
        .clk        (clk),
        .reset      (reset),
        .accept     (accept),
        .misaligned (misaligned),
        .isStore    (heldReq.isStore),
        .timerDone  (timerDone),
        .timerStart (timerStart),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .loadDone   (loadDone),
        .storeDone  (storeDone),
        .fault      (fault),
        .busy       (busy)
    );

    latencyTimer i_latencyTimer (
        .clk   (clk),
        .reset (reset),
        .start (timerStart),
        .done  (timerDone)
    );

    storeAlign i_storeAlign (
        .req        (heldReq),
        .lanes      (lanes),
        .misaligned (misaligned)
    );

    dataMemory i_dataMemory (
        .clk      (clk),
        .reset    (reset),
        .write    (memWrite),
        .read     (memRead),
        .lanes    (lanes),
        .readWord (readWord)
    );

    loadAlign i_loadAlign (
        .word   (readWord),
        .size   (heldReq.size),
        .offset (heldReq.addr[1:0]),
        .data   (loadData)
    );

    // Upper address bits are not decoded, so they must stay inside the array
    assert property (@(posedge clk) disable iff (reset)
        accept |-> (req.addr <= 32'(LAST_BYTE_ADDR)))
        else $error("loadStoreUnit: address beyond data memory");

endmodule

// ==== bench/lsuBench.sv ====
`timescale 1ns/1ns

module lsuBench
    import lsuTypesPkg::*;
();

    localparam int CLK_PERIOD        = 40;
    localparam int DRIVE_DELAY       = 2;
    localparam int RESET_CYCLES      = 4;
    localparam int CYCLES_PER_VECTOR = 10;
    localparam int SETTLE_CYCLES     = 4;  // Slack for the reset check
    localparam int COMPLETION_LIMIT  = 8;  // Cycles to wait for a pulse
    localparam int QUIET_CYCLES      = 3;  // No further pulse allowed here

    localparam logic [1:0] KIND_LOAD  = 2'd0;
    localparam logic [1:0] KIND_STORE = 2'd1;
    localparam logic [1:0] KIND_FAULT = 2'd2;

    typedef struct packed {
        logic        isStore;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] storeData;
        logic [31:0] instNum;
        logic [1:0]  expKind;
        logic [31:0] expValue;
        logic [15:0] lineNo;
    } vector_t;

    logic        clk;
    logic        reset;
    logic        reqStrobe;
    lsReq_t      req;
    loadResult_t result;
    logic        loadDone;
    logic        storeDone;
    logic        fault;
    logic        busy;

    vector_t     vectors[$];
    int          errorCount = 0;
    int          checkCount = 0;
    logic [31:0] randState  = 32'd36;
    bit          loaded     = 1'b0;

    loadStoreUnit i_loadStoreUnit (
        .clk       (clk),
        .reset     (reset),
        .reqStrobe (reqStrobe),
        .req       (req),
        .result    (result),
        .loadDone  (loadDone),
        .storeDone (storeDone),
        .fault     (fault),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic readVectors();
        int          fd;
        int          lineNo;
        int          fields;
        string       line;
        string       opText;
        string       outText;
        logic [31:0] funct3Val;
        logic [31:0] addrVal;
        logic [31:0] dataVal;
        logic [31:0] tagVal;
        logic [31:0] expVal;
        vector_t     vec;
        fd = $fopen("bench/lsuVectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file bench/lsuVectors.txt");
            errorCount++;
            return;
        end
        lineNo = 0;
        while ($fgets(line, fd) > 0) begin
            lineNo++;
            if (line.len() > 0 && line.getc(0) == "#") begin
                continue;  // Column header
            end
            fields = $sscanf(line, "%s %h %h %h %h %s", opText, funct3Val, addrVal,
                             dataVal, tagVal, outText);
            if (fields <= 0) begin
                continue;
            end
            if (fields != 6 || (opText != "load" && opText != "store")) begin
                $display("Vector file line %0d could not be read", lineNo);
                errorCount++;
                continue;
            end
            vec           = '0;
            vec.isStore   = (opText == "store");
            vec.funct3    = funct3Val[2:0];
            vec.addr      = addrVal;
            vec.storeData = dataVal;
            vec.instNum   = tagVal;
            vec.lineNo    = 16'(lineNo);
            if (outText == "store") begin
                vec.expKind = KIND_STORE;
            end else if (outText == "fault") begin
                vec.expKind = KIND_FAULT;
            end else begin
                vec.expKind = KIND_LOAD;
                void'($sscanf(outText, "%h", expVal));
                vec.expValue = expVal;
            end
            vectors.push_back(vec);
        end
        $fclose(fd);
    endtask

    task automatic runVector(input int index, input vector_t vec);
        string  name;
        lsReq_t junk;
        bit     sendJunk;
        bit     seen;
        int     waited;
        name      = $sformatf("vector %0d (line %0d)", index, vec.lineNo);
        randState = lcgNext(randState);
        sendJunk  = randState[28];
        junk      = '{isStore: 1'b1, size: sizeWord, addr: {22'd0, randState[19:12], 2'b00},
                      storeData: lcgNext(randState), instNum: 32'hBAD0_0000 | index};
        @(posedge clk);
        #DRIVE_DELAY;
        req.isStore   = vec.isStore;
        req.size      = accessSize_t'(vec.funct3);
        req.addr      = vec.addr;
        req.storeData = vec.storeData;
        req.instNum   = vec.instNum;
        reqStrobe     = 1'b1;
        @(posedge clk);  // Accept edge
        #DRIVE_DELAY;
        if (sendJunk) begin
            req = junk;  // Lands while busy
        end else begin
            reqStrobe = 1'b0;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        reqStrobe = 1'b0;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < COMPLETION_LIMIT) begin
            @(negedge clk);
            waited++;
            seen = loadDone || storeDone || fault;
            if (!seen && !busy) begin
                $display("%s dropped busy before its completion pulse", name);
                errorCount++;
            end
        end
        checkCount++;
        if (!seen) begin
            $display("%s got no completion pulse within %0d cycles", name, COMPLETION_LIMIT);
            errorCount++;
        end else if ($countones({loadDone, storeDone, fault}) > 1) begin
            $display("%s got more than one completion pulse in one cycle", name);
            errorCount++;
        end else if (vec.expKind == KIND_LOAD) begin
            if (!loadDone) begin
                $display("%s expected a load completion but got %s", name,
                         storeDone ? "a store completion" : "a fault");
                errorCount++;
            end else begin
                checkValue({name, " data"}, vec.expValue, result.data);
                checkValue({name, " instNum"}, vec.instNum, result.instNum);
            end
        end else if (vec.expKind == KIND_STORE) begin
            if (!storeDone) begin
                $display("%s expected a store completion but got %s", name,
                         loadDone ? "a load completion" : "a fault");
                errorCount++;
            end
        end else if (!fault) begin
            $display("%s expected a fault but the operation completed", name);
            errorCount++;
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            checkCount++;
            if (loadDone || storeDone || fault) begin
                $display("%s was followed by an extra completion pulse", name);
                errorCount++;
            end
            if (busy) begin
                $display("%s left busy high after its completion", name);
                errorCount++;
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        reqStrobe = 1'b0;
        req       = '0;
        readVectors();
        loaded = 1'b1;
        if (vectors.size() == 0) begin
            $display("No vectors were loaded");
            errorCount++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        checkCount++;
        if (loadDone || storeDone || fault || busy) begin
            $display("Completion or busy outputs are not low after reset");
            errorCount++;
        end
        checkValue("reset result data", 32'd0, result.data);
        checkValue("reset result instNum", 32'd0, result.instNum);
        foreach (vectors[i]) begin
            runVector(i, vectors[i]);
        end
        $display("Ran %0d vectors with %0d checks and %0d errors", vectors.size(),
                 checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((vectors.size() * CYCLES_PER_VECTOR + RESET_CYCLES + SETTLE_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all vectors finished");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== bench/lsuVectors.txt ====
# op funct3 byteAddr storeData instNum expected
# expected is the load value in hex, or store, or fault
load  2 00000000 00000000 00000001 00000003
load  2 00000014 00000000 00000002 00000008
load  2 000003FC 00000000 00000003 00000102
load  4 000003FD 00000000 00000004 00000001
load  5 000003FC 00000000 00000005 00000102
load  4 00000010 00000000 00000006 00000007
store 0 00000040 000000A1 00000007 store
store 0 00000041 000000B2 00000008 store
store 0 00000042 000000C3 00000009 store
store 0 00000043 123456D4 0000000A store
load  2 00000040 00000000 0000000B D4C3B2A1
load  0 00000043 00000000 0000000C FFFFFFD4
load  4 00000043 00000000 0000000D 000000D4
load  0 00000040 00000000 0000000E FFFFFFA1
load  1 00000042 00000000 0000000F FFFFD4C3
load  5 00000042 00000000 00000010 0000D4C3
load  1 00000040 00000000 00000011 FFFFB2A1
load  0 00000014 00000000 00000012 00000008
store 1 00000044 ABCD8765 00000013 store
store 1 00000046 11117F00 00000014 store
load  2 00000044 00000000 00000015 7F008765
load  1 00000046 00000000 00000016 00007F00
load  1 00000044 00000000 00000017 FFFF8765
store 2 00000048 CAFEF00D 00000018 store
load  2 00000048 00000000 00000019 CAFEF00D
load  1 00000041 00000000 0000001A fault
load  2 00000042 00000000 0000001B fault
store 1 00000043 FFFFFFFF 0000001C fault
store 2 00000041 FFFFFFFF 0000001D fault
load  3 00000040 00000000 0000001E fault
store 3 00000040 FFFFFFFF 0000001F fault
load  5 00000005 00000000 00000020 fault
store 2 0000004A 00000000 00000021 fault
load  2 00000040 00000000 00000022 D4C3B2A1
load  2 00000048 00000000 00000023 CAFEF00D

// ==== project.f ====
src/memConfigPkg.sv
src/lsuTypesPkg.sv
src/latencyTimer.sv
src/storeAlign.sv
src/dataMemory.sv
src/loadAlign.sv
src/lsuControl.sv
src/loadStoreUnit.sv
bench/lsuBench.sv

// ==== Bender.yml ====
package:
  name: load_store_unit

sources:
  - src/memConfigPkg.sv
  - src/lsuTypesPkg.sv
  - src/latencyTimer.sv
  - src/storeAlign.sv
  - src/dataMemory.sv
  - src/loadAlign.sv
  - src/lsuControl.sv
  - src/loadStoreUnit.sv
  - target: test
    files:
      - bench/lsuBench.sv
